// File: design/videoPkg.sv
package videoPkg;

	//////////////////////////////////////////////////
	// Register map

	localparam logic [7:0] ADR_CONTROL = 8'h00;
	localparam logic [7:0] ADR_CURSOR = 8'h04;
	// Entry n lives at ADR_PALETTE + 4n
	localparam logic [7:0] ADR_PALETTE = 8'h40;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Control register bit positions, multi-bit fields give their lsb
	localparam int CTL_FLASH = 0;
	localparam int CTL_TXT = 1;
	localparam int CTL_RATE = 2;
	localparam int CTL_FAST = 4;
	localparam int CTL_CURSOR = 5;

	//////////////////////////////////////////////////
	// Beats between the video stages

	typedef struct packed {
		logic disen;
		logic hsync;
		logic vsync;
		logic cursor;
		logic [4:0] rowAdr;
	} timingBeat_t;

	typedef struct packed {
		logic [3:0] colourIdx;
		logic [3:0] cursorSeg;
		logic disen;
		logic rowAdr3;
		logic hsync;
		logic vsync;
	} pixelBeat_t;

	typedef struct packed {
		logic [7:0] control;
		logic [13:0] cursorAdr;
	} ctrlRegs_t;

endpackage

// File: design/videoUlaRegs.sv
`timescale 1ns/1ps

module videoUlaRegs import videoPkg::*; (
	input logic CLK,
	input logic nRESET,
	input logic [7:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [7:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output ctrlRegs_t regs,
	input logic [3:0] paletteIdx,
	output logic [3:0] paletteOut
);

	logic [3:0] palette [16];
	logic wrStart, wrAccept, wrPal, wrHit;
	logic rdStart, rdAccept, rdPal, rdHit;
	logic [31:0] rdValue;

	// Palette slots are word aligned inside 0x40..0x7C
	assign wrPal = (awaddr[7:6] == ADR_PALETTE[7:6]) && (awaddr[1:0] == 2'b00);
	assign wrHit = (awaddr == ADR_CONTROL) || (awaddr == ADR_CURSOR) || wrPal;
	assign rdPal = (araddr[7:6] == ADR_PALETTE[7:6]) && (araddr[1:0] == 2'b00);
	assign rdHit = (araddr == ADR_CONTROL) || (araddr == ADR_CURSOR) || rdPal;

	assign wrStart = awvalid && wvalid && !awready && !bvalid;
	assign wrAccept = awvalid && awready && wvalid && wready;
	assign rdStart = arvalid && !arready && !rvalid;
	assign rdAccept = arvalid && arready;

	// Lookup for the colour stage
	assign paletteOut = palette[paletteIdx];

	//////////////////////////////////////////////////
	// Write channel

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= RESP_OKAY;
		end else begin
			awready <= wrStart;
			wready <= wrStart;
			if (wrAccept) begin
				bvalid <= 1'b1;
				bresp <= wrHit ? RESP_OKAY : RESP_SLVERR;
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			regs <= '0;
			for (int i = 0; i < 16; i++) begin
				palette[i] <= 4'(i);
			end
		end else if (wrAccept) begin
			if (awaddr == ADR_CONTROL) begin
				regs.control <= wdata[7:0];
			end else if (awaddr == ADR_CURSOR) begin
				regs.cursorAdr <= wdata[13:0];
			end else if (wrPal) begin
				palette[awaddr[5:2]] <= wdata[3:0];
			end
		end
	end

	//////////////////////////////////////////////////
	// Read channel

	always_comb begin
		rdValue = '0;
		if (araddr == ADR_CONTROL) begin
			rdValue[7:0] = regs.control;
		end else if (araddr == ADR_CURSOR) begin
			rdValue[13:0] = regs.cursorAdr;
		end else if (rdPal) begin
			rdValue[3:0] = palette[araddr[5:2]];
		end
	end

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			arready <= rdStart;
			if (rdAccept) begin
				rvalid <= 1'b1;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// Unmapped reads return zero data
	always_ff @(posedge CLK) begin
		if (rdAccept) begin
			rdata <= rdValue;
			rresp <= rdHit ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// No second write is taken while a write response is still pending
	oneWritePerResponse: assert property (@(posedge CLK) disable iff (!nRESET)
		wrAccept |-> !bvalid);

endmodule

// File: design/crtcTiming.sv
`timescale 1ns/1ps

module crtcTiming import videoPkg::*; #(
	parameter int H_TOTAL = 16,
	parameter int H_DISPLAYED = 10,
	parameter int H_SYNC_POS = 12,
	parameter int H_SYNC_WIDTH = 2,
	parameter int V_TOTAL = 8,
	parameter int V_DISPLAYED = 6,
	parameter int V_SYNC_POS = 7,
	parameter int SCANLINES = 10,
	parameter int START_ADR = 256
) (
	input logic CLK,
	input logic nRESET,
	input logic fast,
	input logic [13:0] cursorAdr,
	output timingBeat_t beat,
	output logic [13:0] frameAdr,
	output logic charStart
);

	logic [3:0] cycCnt;
	logic [7:0] charCnt;
	logic [4:0] scanCnt;
	logic [6:0] rowCnt;
	logic charEnd, lineEnd, rowEnd, frameEnd;
	logic disen;

	// 8 cycles per character in fast mode, 16 otherwise.
	// A mode switch mid-character finishes at the next 8-cycle boundary
	assign charEnd = (cycCnt[2:0] == 3'd7) && (fast || cycCnt[3]);
	assign lineEnd = charCnt == 8'(H_TOTAL - 1);
	assign rowEnd = scanCnt == 5'(SCANLINES - 1);
	assign frameEnd = rowCnt == 7'(V_TOTAL - 1);

	//////////////////////////////////////////////////
	// Counters

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			cycCnt <= '0;
			charCnt <= '0;
			scanCnt <= '0;
			rowCnt <= '0;
		end else begin
			cycCnt <= charEnd ? 4'd0 : cycCnt + 4'd1;
			if (charEnd) begin
				charCnt <= lineEnd ? 8'd0 : charCnt + 8'd1;
				if (lineEnd) begin
					scanCnt <= rowEnd ? 5'd0 : scanCnt + 5'd1;
					if (rowEnd) begin
						rowCnt <= frameEnd ? 7'd0 : rowCnt + 7'd1;
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Decoded timing, stable for a whole character

	assign charStart = cycCnt == 4'd0;
	assign disen = (int'(charCnt) < H_DISPLAYED) && (int'(rowCnt) < V_DISPLAYED);

	// Linear framestore, one byte per character
	assign frameAdr = 14'(START_ADR + int'(rowCnt) * H_DISPLAYED + int'(charCnt));

	assign beat.disen = disen;
	assign beat.hsync = (int'(charCnt) >= H_SYNC_POS)
		&& (int'(charCnt) < H_SYNC_POS + H_SYNC_WIDTH);
	assign beat.vsync = int'(rowCnt) == V_SYNC_POS;
	assign beat.cursor = disen && (frameAdr == cursorAdr);
	assign beat.rowAdr = scanCnt;

	// Catches geometry that overflows the 14-bit framestore
	frameAdrInDisplay: assert property (@(posedge CLK) disable iff (!nRESET)
		disen |-> (int'(frameAdr) >= START_ADR)
			&& (int'(frameAdr) < START_ADR + V_DISPLAYED * H_DISPLAYED));

endmodule

// File: design/pixelShifter.sv
`timescale 1ns/1ps

module pixelShifter import videoPkg::*; (
	input logic CLK,
	input logic nRESET,
	input logic [1:0] rate,
	input logic charStart,
	input logic [7:0] vData,
	input timingBeat_t beatIn,
	output pixelBeat_t pixel
);

	logic startD1;
	timingBeat_t beatD1, beatD2;
	logic [7:0] shifter;
	logic [2:0] phase;
	logic [2:0] mask;
	logic shiftEn;
	logic [3:0] cursorSeg;

	// Shift every 8, 4, 2 or 1 cycles
	always_comb begin
		case (rate)
			2'd0: mask = 3'd7;
			2'd1: mask = 3'd3;
			2'd2: mask = 3'd1;
			default: mask = 3'd0;
		endcase
	end

	assign shiftEn = (phase & mask) == mask;

	//////////////////////////////////////////////////
	// Timing alignment and cursor segments

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			startD1 <= 1'b0;
			beatD1 <= '0;
			beatD2 <= '0;
			phase <= '0;
			cursorSeg <= '0;
		end else begin
			startD1 <= charStart;
			beatD1 <= beatIn;
			beatD2 <= beatD1;
			phase <= startD1 ? 3'd0 : phase + 3'd1;
			// Segment 0 is the cursor character itself and the rest trail it
			if (startD1) begin
				cursorSeg <= {cursorSeg[2:0], beatD1.cursor};
			end
		end
	end

	// vData arrives one cycle after the address and loads as it lands
	always_ff @(posedge CLK) begin
		if (startD1) begin
			shifter <= vData;
		end else if (shiftEn) begin
			shifter <= {shifter[6:0], 1'b1};
		end
	end

	assign pixel.colourIdx = {shifter[7], shifter[5], shifter[3], shifter[1]};
	assign pixel.cursorSeg = cursorSeg;
	assign pixel.disen = beatD2.disen;
	assign pixel.rowAdr3 = beatD2.rowAdr[3];
	assign pixel.hsync = beatD2.hsync;
	assign pixel.vsync = beatD2.vsync;

endmodule

// File: design/colourStage.sv
`timescale 1ns/1ps

module colourStage import videoPkg::*; (
	input logic CLK,
	input logic nRESET,
	input logic [7:0] control,
	input pixelBeat_t pixel,
	output logic [3:0] paletteIdx,
	input logic [3:0] paletteOut,
	output logic [2:0] rgb,
	output logic hsync,
	output logic vsync
);

	logic [2:0] colour;
	logic [2:0] shown;
	logic [2:0] rgbNext;
	logic blank;
	logic cursorDraw;

	assign paletteIdx = pixel.colourIdx;

	// Flashing entries swap to their complement
	assign colour = (control[CTL_FLASH] && paletteOut[3]) ? ~paletteOut[2:0] : paletteOut[2:0];

	// Scanlines 8 and up of each row are the gap between character rows
	assign blank = !pixel.disen || pixel.rowAdr3 || control[CTL_TXT];
	assign shown = blank ? 3'b000 : colour;

	// Top control bit picks the first segment, bit 5 covers the last two
	assign cursorDraw = (control[CTL_CURSOR + 2] && pixel.cursorSeg[0])
		|| (control[CTL_CURSOR + 1] && pixel.cursorSeg[1])
		|| (control[CTL_CURSOR] && (pixel.cursorSeg[2] || pixel.cursorSeg[3]));

	assign rgbNext = cursorDraw ? ~shown : shown;

	//////////////////////////////////////////////////
	// Output register, syncs ride along with the pixel

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			rgb <= 3'b000;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end else begin
			rgb <= rgbNext;
			hsync <= pixel.hsync;
			vsync <= pixel.vsync;
		end
	end

endmodule

// File: design/displayControl.sv
`timescale 1ns/1ps

module displayControl import videoPkg::*; #(
	parameter int H_TOTAL = 16,
	parameter int H_DISPLAYED = 10,
	parameter int H_SYNC_POS = 12,
	parameter int H_SYNC_WIDTH = 2,
	parameter int V_TOTAL = 8,
	parameter int V_DISPLAYED = 6,
	parameter int V_SYNC_POS = 7,
	parameter int SCANLINES = 10,
	parameter int START_ADR = 256
) (
	input logic CLK,
	input logic nRESET,
	input logic [7:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [7:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic [13:0] frameAdr,
	input logic [7:0] vData,
	output logic [4:0] rowAdr,
	output logic [2:0] rgb,
	output logic hsync,
	output logic vsync
);

	ctrlRegs_t regs;
	timingBeat_t beat;
	pixelBeat_t pixel;
	logic charStart;
	logic [3:0] paletteIdx;
	logic [3:0] paletteOut;

	assign rowAdr = beat.rowAdr;

	//////////////////////////////////////////////////
	// Host registers

	videoUlaRegs regs_i (
		.CLK(CLK),
		.nRESET(nRESET),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.regs(regs),
		.paletteIdx(paletteIdx),
		.paletteOut(paletteOut)
	);

	//////////////////////////////////////////////////
	// Video path

	crtcTiming #(
		.H_TOTAL(H_TOTAL),
		.H_DISPLAYED(H_DISPLAYED),
		.H_SYNC_POS(H_SYNC_POS),
		.H_SYNC_WIDTH(H_SYNC_WIDTH),
		.V_TOTAL(V_TOTAL),
		.V_DISPLAYED(V_DISPLAYED),
		.V_SYNC_POS(V_SYNC_POS),
		.SCANLINES(SCANLINES),
		.START_ADR(START_ADR)
	) crtc_i (
		.CLK(CLK),
		.nRESET(nRESET),
		.fast(regs.control[CTL_FAST]),
		.cursorAdr(regs.cursorAdr),
		.beat(beat),
		.frameAdr(frameAdr),
		.charStart(charStart)
	);

	pixelShifter shifter_i (
		.CLK(CLK),
		.nRESET(nRESET),
		.rate(regs.control[CTL_RATE +: 2]),
		.charStart(charStart),
		.vData(vData),
		.beatIn(beat),
		.pixel(pixel)
	);

	colourStage colour_i (
		.CLK(CLK),
		.nRESET(nRESET),
		.control(regs.control),
		.pixel(pixel),
		.paletteIdx(paletteIdx),
		.paletteOut(paletteOut),
		.rgb(rgb),
		.hsync(hsync),
		.vsync(vsync)
	);

endmodule

// File: verification/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 4
) (
	output logic CLK,
	output logic nRESET
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	// Release just after a rising edge so the first active edge is clean
	initial begin
		nRESET = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#2 nRESET = 1'b1;
	end

endmodule

// File: verification/displayControlTb.sv
`timescale 1ns/1ps

module displayControlTb import videoPkg::*; ();

	localparam int H_TOTAL = 16;
	localparam int H_DISPLAYED = 10;
	localparam int H_SYNC_POS = 12;
	localparam int H_SYNC_WIDTH = 2;
	localparam int V_TOTAL = 8;
	localparam int V_DISPLAYED = 6;
	localparam int V_SYNC_POS = 7;
	localparam int SCANLINES = 10;
	localparam int START_ADR = 256;
	localparam int FRAME_CHARS = H_TOTAL * V_TOTAL * SCANLINES;
	localparam int NUM_TESTS = 6;

	localparam logic [1:0] PAL_RANDOM = 2'd0;
	localparam logic [1:0] PAL_FLASH = 2'd1;
	localparam logic [1:0] CLS_PIXEL = 2'd0;
	localparam logic [1:0] CLS_BLANK = 2'd1;
	localparam logic [1:0] CLS_CURSOR = 2'd2;

	typedef struct packed {
		logic [7:0] control;
		logic [13:0] cursor;
		logic [1:0] palFill;
		logic [1:0] resultClass;
	} testRow_t;

	// What the outputs must show three cycles after a model cycle
	typedef struct packed {
		logic valid;
		logic armed;
		logic hsync;
		logic vsync;
		logic lit;
		logic inverted;
		logic [2:0] rgb;
	} expectBeat_t;

	logic CLK, nRESET;
	logic [7:0] awaddr, araddr, vData, fetched;
	logic awvalid, wvalid, bready, arvalid, rready;
	logic awready, wready, bvalid, arready, rvalid;
	logic [31:0] wdata, rdata;
	logic [1:0] bresp, rresp;
	logic [13:0] frameAdr;
	logic [4:0] rowAdr;
	logic [2:0] rgb;
	logic hsync, vsync;

	testRow_t tests [NUM_TESTS];
	integer seed;
	logic wantCheck;
	logic [7:0] lastAdr;
	logic [31:0] lastData;
	logic [3:0] palShadow [16];
	logic [13:0] cursorShadow;

	// Reference model state
	int mCyc, mChr, mScan, mRow;
	logic [7:0] modelCtl;
	logic bvalidD, armed, hsPrev, vsPrev, hsArm, frameSeen;
	expectBeat_t pipe [3];
	int hsLen, hsRises, litCount, invCount, shownCount;

	clockGen clock_i (.CLK(CLK), .nRESET(nRESET));

	displayControl #(
		.H_TOTAL(H_TOTAL), .H_DISPLAYED(H_DISPLAYED), .H_SYNC_POS(H_SYNC_POS),
		.H_SYNC_WIDTH(H_SYNC_WIDTH), .V_TOTAL(V_TOTAL), .V_DISPLAYED(V_DISPLAYED),
		.V_SYNC_POS(V_SYNC_POS), .SCANLINES(SCANLINES), .START_ADR(START_ADR)
	) displayControl_i (
		.CLK(CLK), .nRESET(nRESET),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.frameAdr(frameAdr), .vData(vData), .rowAdr(rowAdr),
		.rgb(rgb), .hsync(hsync), .vsync(vsync)
	);

	//////////////////////////////////////////////////
	// Helpers

	task automatic stopRun();
		$display("Regression failed");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic checkEq(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			$display("ERR %s got 0x%h expected 0x%h at %0t", name, got, want, $time);
			stopRun();
		end
	endtask

	function automatic int shiftInterval(input logic [7:0] ctl);
		return 8 >> ctl[CTL_RATE +: 2];
	endfunction

	// Index from bits 7 5 3 1 of the byte shifted left with ones behind it
	function automatic logic [2:0] pixelColour(input logic [7:0] data, input int shifts,
		input logic [7:0] ctl);
		logic [7:0] sh;
		logic [3:0] idx;
		logic [3:0] p;
		sh = data;
		for (int i = 0; i < shifts; i++) begin
			sh = {sh[6:0], 1'b1};
		end
		idx = {sh[7], sh[5], sh[3], sh[1]};
		p = palShadow[idx];
		return (ctl[CTL_FLASH] && p[3]) ? ~p[2:0] : p[2:0];
	endfunction

	//////////////////////////////////////////////////
	// AXI4-Lite host

	task automatic axiWrite(input logic [7:0] adr, input logic [31:0] data,
		output logic [1:0] resp);
		int n;
		n = 0;
		lastAdr = adr;
		lastData = data;
		@(posedge CLK);
		#2;
		awaddr = adr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		do begin
			@(negedge CLK);
			n++;
		end while (!(awready && wready) && n < 16);
		if (!(awready && wready)) begin
			$display("AXI write was never accepted");
			stopRun();
		end
		@(posedge CLK);
		#2;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b1;
		@(negedge CLK);
		if (!bvalid) begin
			$display("AXI write response did not arrive");
			stopRun();
		end
		resp = bresp;
		@(posedge CLK);
		#2 bready = 1'b0;
	endtask

	task automatic axiRead(input logic [7:0] adr, output logic [31:0] data,
		output logic [1:0] resp);
		int n;
		n = 0;
		@(posedge CLK);
		#2;
		araddr = adr;
		arvalid = 1'b1;
		do begin
			@(negedge CLK);
			n++;
		end while (!arready && n < 16);
		if (!arready) begin
			$display("AXI read was never accepted");
			stopRun();
		end
		@(posedge CLK);
		#2;
		arvalid = 1'b0;
		rready = 1'b1;
		@(negedge CLK);
		if (!rvalid) begin
			$display("AXI read data did not arrive");
			stopRun();
		end
		data = rdata;
		resp = rresp;
		@(posedge CLK);
		#2 rready = 1'b0;
	endtask

	task automatic writeReg(input logic [7:0] adr, input logic [31:0] data,
		input logic [31:0] mask);
		logic [1:0] resp;
		logic [31:0] back;
		axiWrite(adr, data, resp);
		checkEq("bresp", 32'(resp), 32'(RESP_OKAY));
		axiRead(adr, back, resp);
		checkEq("rresp", 32'(resp), 32'(RESP_OKAY));
		checkEq("rdata", back, data & mask);
	endtask

	task automatic runTest(input testRow_t row);
		logic [3:0] value;
		int period, litStart, invStart, shownStart;
		@(posedge CLK);
		#2 wantCheck = 1'b0;
		for (int i = 0; i < 16; i++) begin
			value = 4'($random(seed));
			if (row.palFill == PAL_FLASH) begin
				value[3] = 1'b1;
			end
			palShadow[i] = value;
			writeReg(ADR_PALETTE + 8'(4 * i), 32'(value), 32'h0000_000f);
		end
		cursorShadow = row.cursor;
		writeReg(ADR_CURSOR, 32'(row.cursor), 32'h0000_3fff);
		writeReg(ADR_CONTROL, 32'(row.control), 32'h0000_00ff);
		period = row.control[CTL_FAST] ? 8 : 16;
		litStart = litCount;
		invStart = invCount;
		shownStart = shownCount;
		@(posedge CLK);
		#2 wantCheck = 1'b1;
		// One whole frame under the new settings
		repeat (FRAME_CHARS * period) @(posedge CLK);
		case (row.resultClass)
			CLS_PIXEL: checkEq("lit pixels seen", 32'(litCount > litStart), 32'd1);
			CLS_BLANK: checkEq("non-black pixels", 32'(shownCount - shownStart), 32'd0);
			default: checkEq("cursor pixels seen", 32'(invCount > invStart), 32'd1);
		endcase
	endtask

	//////////////////////////////////////////////////
	// Framestore model with one cycle of read latency

	always @(negedge CLK) begin
		fetched = frameAdr[7:0] ^ 8'hA5;
	end

	always @(posedge CLK) begin
		#2 vData = fetched;
	end

	//////////////////////////////////////////////////
	// Reference timing and pixel model stepping once per cycle

	always @(negedge CLK) begin
		expectBeat_t nb;
		logic [13:0] adr;
		logic disen;
		logic [2:0] shown;
		if (!nRESET) begin
			mCyc = 0;
			mChr = 0;
			mScan = 0;
			mRow = 0;
			modelCtl = '0;
			bvalidD = 1'b0;
			armed = 1'b0;
			hsPrev = 1'b0;
			vsPrev = 1'b0;
			hsArm = 1'b0;
			frameSeen = 1'b0;
			hsLen = 0;
			hsRises = 0;
			litCount = 0;
			invCount = 0;
			shownCount = 0;
			for (int i = 0; i < 3; i++) begin
				pipe[i] = '0;
			end
		end else begin
			// Control takes effect on the edge that raises BVALID
			if (bvalid && !bvalidD && lastAdr == ADR_CONTROL) begin
				modelCtl = lastData[7:0];
			end
			bvalidD = bvalid;
			if (!wantCheck) begin
				armed = 1'b0;
			end else if (mCyc == 0) begin
				armed = 1'b1;
			end

			if (pipe[2].valid) begin
				checkEq("hsync", 32'(hsync), 32'(pipe[2].hsync));
				checkEq("vsync", 32'(vsync), 32'(pipe[2].vsync));
				if (pipe[2].armed) begin
					checkEq("rgb", 32'(rgb), 32'(pipe[2].rgb));
					litCount += int'(pipe[2].lit && rgb != 3'b000);
					invCount += int'(pipe[2].inverted && rgb != 3'b000);
					shownCount += int'(rgb != 3'b000);
				end
			end

			// Sync pulse geometry
			if (hsync && !hsPrev) begin
				hsLen = 0;
				hsArm = armed;
				hsRises++;
			end
			if (hsync) begin
				hsLen++;
			end
			if (!armed) begin
				hsArm = 1'b0;
			end
			if (!hsync && hsPrev && hsArm) begin
				checkEq("hsync width", 32'(hsLen),
					32'(H_SYNC_WIDTH * (modelCtl[CTL_FAST] ? 8 : 16)));
			end
			if (vsync && !vsPrev) begin
				if (frameSeen) begin
					checkEq("hsync per frame", 32'(hsRises), 32'(V_TOTAL * SCANLINES));
				end
				frameSeen = 1'b1;
				hsRises = 0;
			end
			hsPrev = hsync;
			vsPrev = vsync;

			adr = 14'(START_ADR + mRow * H_DISPLAYED + mChr);
			disen = (mChr < H_DISPLAYED) && (mRow < V_DISPLAYED);
			if (mCyc == 0 && disen) begin
				checkEq("frameAdr", 32'(frameAdr), 32'(adr));
			end
			checkEq("rowAdr", 32'(rowAdr), 32'(mScan));

			nb.valid = 1'b1;
			nb.armed = armed;
			nb.hsync = (mChr >= H_SYNC_POS) && (mChr < H_SYNC_POS + H_SYNC_WIDTH);
			nb.vsync = mRow == V_SYNC_POS;
			nb.lit = disen && ((mScan & 8) == 0) && !modelCtl[CTL_TXT];
			nb.inverted = modelCtl[CTL_CURSOR + 2] && disen && (adr == cursorShadow);
			shown = 3'b000;
			if (nb.lit) begin
				shown = pixelColour(adr[7:0] ^ 8'hA5,
					mCyc / shiftInterval(modelCtl), modelCtl);
			end
			nb.rgb = nb.inverted ? ~shown : shown;
			pipe[2] = pipe[1];
			pipe[1] = pipe[0];
			pipe[0] = nb;

			// Character ends on an 8-cycle boundary but only every other one when slow
			if ((mCyc % 8 == 7) && (modelCtl[CTL_FAST] || mCyc >= 8)) begin
				mCyc = 0;
				mChr = (mChr == H_TOTAL - 1) ? 0 : mChr + 1;
				if (mChr == 0) begin
					mScan = (mScan == SCANLINES - 1) ? 0 : mScan + 1;
					if (mScan == 0) begin
						mRow = (mRow == V_TOTAL - 1) ? 0 : mRow + 1;
					end
				end
			end else begin
				mCyc++;
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus

	initial begin
		logic [31:0] data;
		logic [1:0] resp;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		vData = '0;
		fetched = '0;
		wantCheck = 1'b0;
		lastAdr = 8'hff;
		lastData = '0;
		cursorShadow = '0;
		seed = 32'h5336_c224;
		for (int i = 0; i < 16; i++) begin
			palShadow[i] = 4'(i);
		end

		// control, cursor, palette fill, result class
		tests[0] = '{8'h00, 14'd0, PAL_RANDOM, CLS_PIXEL};
		tests[1] = '{8'h15, 14'd0, PAL_FLASH, CLS_PIXEL};
		tests[2] = '{8'h08, 14'd0, PAL_RANDOM, CLS_PIXEL};
		tests[3] = '{8'h1c, 14'd0, PAL_RANDOM, CLS_PIXEL};
		tests[4] = '{8'h02, 14'd0, PAL_RANDOM, CLS_BLANK};
		tests[5] = '{8'h8c, 14'd279, PAL_RANDOM, CLS_CURSOR};

		@(posedge nRESET);
		repeat (2) @(posedge CLK);

		// Unmapped offset
		axiWrite(8'h08, 32'hffff_ffff, resp);
		checkEq("bresp", 32'(resp), 32'(RESP_SLVERR));
		axiRead(8'h08, data, resp);
		checkEq("rresp", 32'(resp), 32'(RESP_SLVERR));
		checkEq("rdata", data, 32'h0);

		for (int t = 0; t < NUM_TESTS; t++) begin
			runTest(tests[t]);
		end
		$display("Regression passed");
		$finish;
	end

	initial begin
		repeat ((NUM_TESTS + 1) * FRAME_CHARS * 16 + 1000) @(posedge CLK);
		$display("Watchdog expired before the tests finished");
		stopRun();
	end

endmodule

// File: all.f
design/videoPkg.sv
design/videoUlaRegs.sv
design/crtcTiming.sv
design/pixelShifter.sv
design/colourStage.sv
design/displayControl.sv
verification/clockGen.sv
verification/displayControlTb.sv

// File: run.sh
#!/bin/bash
# Build and run the display controller regression with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f all.f --top-module displayControlTb \
	-o simv > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

{ ./obj_dir/simv > sim.log 2>&1 || true; } \
	&& ! grep -q "Regression failed" sim.log \
	&& grep -q "Regression passed" sim.log \
	&& echo "Simulation PASSED" \
	|| { echo "Simulation FAILED, see sim.log"; exit 1; }
